//--- common/dcache_pkg.sv
package dcache_pkg;

    // address split for a 64 set, 8 byte line cache with 4 KiB pages
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int TAG_LSB  = OFFSET_W + INDEX_W;
    localparam int TAG_W    = 32 - TAG_LSB;
    localparam int PAGE_W   = 12;

    typedef logic [31:0]           vaddr_t;
    typedef logic [31:0]           paddr_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [OFFSET_W-1:0]   offset_t;
    typedef logic [63:0]           line_t;
    typedef logic [31:0]           word_t;
    typedef logic [31-PAGE_W:0]    vpn_t;
    typedef logic [31-PAGE_W:0]    ppn_t;

    typedef struct packed {
        logic valid;
        vpn_t vpn;
        ppn_t ppn;
        logic pcd;
        logic writable;
    } tlb_entry_t;

    typedef struct packed {
        logic   hit;
        logic   pcd;
        logic   writable;
        paddr_t paddr;
    } tlb_resp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        COMPARE,
        BUS_WAIT,
        FILL,
        WRITE,
        RESPOND,
        FAULT
    } dc_state_e;

    // controller to datapath strobes
    typedef struct packed {
        logic req_addr_en;
        logic pa_en;
        logic staging_en;
        logic wdata_en;     // also picks the write address on req_addr_en
        logic second_sel;
        logic cnt_clr;
        logic cnt_inc;      // beats count while this is high
        logic array_write;
        logic valid_val;
    } dp_ctrl_t;

endpackage

//--- verilog/dtlb.sv
`timescale 1ns/1ps

module dtlb import dcache_pkg::*; #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cfg_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] cfg_index,
    input  tlb_entry_t                     cfg_entry,
    input  vaddr_t                         vaddr,
    output tlb_resp_t                      resp
);

    tlb_entry_t entries [TLB_ENTRIES];
    vpn_t       vpn;

    // configuration side
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (cfg_we) begin
            entries[cfg_index] <= cfg_entry;
        end
    end

    assign vpn = vaddr[31:PAGE_W];

    // fully associative match, entries are expected to be unique
    always_comb begin
        resp = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (entries[i].valid && (entries[i].vpn == vpn)) begin
                resp.hit      = 1'b1;
                resp.pcd      = entries[i].pcd;
                resp.writable = entries[i].writable;
                resp.paddr    = {entries[i].ppn, vaddr[PAGE_W-1:0]};
            end
        end
    end

endmodule

//--- dcache/dcache_arrays.sv
`timescale 1ns/1ps

module dcache_arrays import dcache_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  index_t index,
    input  tag_t   tag,
    input  logic   write,
    input  logic   valid_in,
    input  line_t  wdata,
    output line_t  rdata,
    output logic   cache_hit
);

    localparam int SETS = 1 << INDEX_W;

    tag_t            tag_mem  [SETS];
    line_t           data_mem [SETS];
    logic [SETS-1:0] valid_bits;
    tag_t            tag_q;
    logic            valid_q;

    // synchronous read, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        if (write) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= wdata;
        end
        tag_q <= tag_mem[index];
        rdata <= data_mem[index];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            valid_q    <= 1'b0;
        end else begin
            if (write) begin
                valid_bits[index] <= valid_in;
            end
            valid_q <= valid_bits[index];
        end
    end

    assign cache_hit = valid_q && (tag_q == tag);

endmodule

//--- dcache/d_align.sv
`timescale 1ns/1ps

module d_align import dcache_pkg::*; (
    input  line_t   low_line,
    input  line_t   high_line,
    input  offset_t offset,
    output line_t   result
);

    logic [15:0][7:0] joined;

    assign joined = {high_line, low_line};

    // byte b of the result is byte offset+b of the pair
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            result[b*8 +: 8] = joined[int'(offset) + b];
        end
    end

endmodule

//--- dcache/dcache_datapath.sv
`timescale 1ns/1ps

module dcache_datapath import dcache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  vaddr_t   rd_req_address,
    input  vaddr_t   wr_req_address,
    input  line_t    wr_req_data,
    input  logic     wr_size,
    input  paddr_t   tlb_paddr,
    input  dp_ctrl_t ctrl,
    input  word_t    mem_rdata,
    input  logic     mem_data_valid,
    input  line_t    array_line,
    output vaddr_t   vaddr,
    output paddr_t   mem_addr,
    output word_t    mem_wdata,
    output line_t    fill_line,
    output line_t    low_line,
    output offset_t  offset,
    output logic     second_needed,
    output logic     beat_done,
    output logic     second_line
);

    vaddr_t     req_addr;
    paddr_t     pa_q;
    paddr_t     pa_base;
    line_t      wdata_q;
    line_t      fill_q;
    line_t      staging_q;
    logic       size_q;
    logic       is_write;
    logic [1:0] beat_cnt;
    logic       beat;
    logic       from_fill;

    assign beat = ctrl.cnt_inc && mem_data_valid;

    always_ff @(posedge clk) begin
        if (ctrl.req_addr_en) begin
            req_addr <= ctrl.wdata_en ? wr_req_address : rd_req_address;
        end
        if (ctrl.pa_en) begin
            pa_q <= tlb_paddr;
        end
        if (ctrl.wdata_en) begin
            wdata_q <= wr_req_data;
        end
        if (ctrl.staging_en) begin
            staging_q <= fill_line;
        end
        // first beat is the low word of the line
        if (beat && !beat_cnt[0]) begin
            fill_q[31:0] <= mem_rdata;
        end
        if (beat && beat_cnt[0]) begin
            fill_q[63:32] <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            is_write    <= 1'b0;
            size_q      <= 1'b0;
            second_line <= 1'b0;
            beat_cnt    <= 2'd0;
        end else begin
            if (ctrl.req_addr_en) begin
                is_write    <= ctrl.wdata_en;
                second_line <= 1'b0;
            end else if (ctrl.second_sel) begin
                second_line <= 1'b1;
            end
            if (ctrl.wdata_en) begin
                size_q <= wr_size;
            end
            if (ctrl.cnt_clr) begin
                beat_cnt <= 2'd0;
            end else if (beat) begin
                beat_cnt <= beat_cnt + 2'd1;
            end
        end
    end

    assign vaddr  = second_line ? req_addr + 32'd8 : req_addr;
    assign offset = req_addr[OFFSET_W-1:0];

    // a two word write at bit 2 touches the next line as well
    assign second_needed = is_write ? (size_q && req_addr[2]) : (req_addr[2:0] != 3'd0);
    assign beat_done     = (is_write && !size_q) ? (beat_cnt == 2'd1) : (beat_cnt == 2'd2);

    // current line, from a finished fill or from the array
    assign from_fill = !is_write && (beat_cnt == 2'd2);
    assign fill_line = from_fill ? fill_q : array_line;
    assign low_line  = second_line ? staging_q : fill_line;

    // fills start at the line base, writes at the word
    assign pa_base   = is_write ? pa_q : {pa_q[31:3], 3'b000};
    assign mem_addr  = beat_cnt[0] ? pa_base + 32'd4 : pa_base;
    assign mem_wdata = beat_cnt[0] ? wdata_q[63:32] : wdata_q[31:0];

endmodule

//--- dcache/dcache_controller.sv
`timescale 1ns/1ps

module dcache_controller import dcache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      rd_req_valid,
    input  logic      rd_dp_ready,
    input  logic      wr_req_valid,
    input  logic      cache_hit,
    input  tlb_resp_t tlb,
    input  logic      second_needed,
    input  logic      beat_done,
    input  logic      second_line,
    input  logic      mem_data_valid,
    input  logic      grant_in,
    input  logic      bus_busy_in,
    output logic      rd_req_ready,
    output logic      rd_dp_valid,
    output logic      wr_req_ready,
    output logic      page_fault,
    output dp_ctrl_t  ctrl,
    output logic      mem_req,
    output logic      mem_rd_wr,
    output logic      bus_busy_out,
    output logic      grant_out
);

    dc_state_e state;
    dc_state_e state_next;
    logic      is_write;
    logic      take_rd;
    logic      take_wr;
    logic      xfer;
    logic      fault;
    logic      next_line;

    // reads win when both ports ask in the same cycle
    assign take_rd   = (state == IDLE) && rd_req_valid;
    assign take_wr   = (state == IDLE) && wr_req_valid && !rd_req_valid;
    assign xfer      = (state == FILL) || (state == WRITE);
    assign fault     = !tlb.hit || (is_write && !tlb.writable);
    assign next_line = second_needed && !second_line;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            is_write <= 1'b0;
        end else begin
            state <= state_next;
            if (take_rd || take_wr) begin
                is_write <= take_wr;
            end
        end
    end

    always_comb begin
        state_next = state;
        ctrl       = '0;
        case (state)
            IDLE: begin
                if (take_rd || take_wr) begin
                    ctrl.req_addr_en = 1'b1;
                    ctrl.wdata_en    = take_wr;
                    ctrl.cnt_clr     = 1'b1;
                    state_next       = LOOKUP;
                end
            end
            LOOKUP: begin
                // translation is already valid here, so faults leave early
                state_next = fault ? FAULT : COMPARE;
            end
            COMPARE: begin
                // a write keeps the address of its first line
                ctrl.pa_en = !(is_write && second_line);
                if (is_write) begin
                    ctrl.array_write = cache_hit;
                    if (next_line) begin
                        ctrl.second_sel = 1'b1;
                        ctrl.cnt_clr    = 1'b1;
                        state_next      = LOOKUP;
                    end else begin
                        state_next = BUS_WAIT;
                    end
                end else if (tlb.pcd || !cache_hit) begin
                    state_next = BUS_WAIT;
                end else if (next_line) begin
                    ctrl.staging_en = 1'b1;
                    ctrl.second_sel = 1'b1;
                    ctrl.cnt_clr    = 1'b1;
                    state_next      = LOOKUP;
                end else begin
                    state_next = RESPOND;
                end
            end
            BUS_WAIT: begin
                if (grant_in && !bus_busy_in) begin
                    state_next = is_write ? WRITE : FILL;
                end
            end
            FILL: begin
                ctrl.cnt_inc = 1'b1;
                if (beat_done) begin
                    // uncacheable data goes straight to the response
                    ctrl.array_write = !tlb.pcd;
                    ctrl.valid_val   = 1'b1;
                    if (next_line) begin
                        ctrl.staging_en = 1'b1;
                        ctrl.second_sel = 1'b1;
                        ctrl.cnt_clr    = 1'b1;
                        state_next      = LOOKUP;
                    end else begin
                        state_next = RESPOND;
                    end
                end
            end
            WRITE: begin
                ctrl.cnt_inc = 1'b1;
                if (beat_done) begin
                    state_next = IDLE;
                end
            end
            RESPOND: begin
                if (rd_dp_ready) begin
                    state_next = IDLE;
                end
            end
            FAULT: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign rd_req_ready = (state == IDLE);
    assign wr_req_ready = (state == IDLE) && !rd_req_valid;
    assign rd_dp_valid  = (state == RESPOND);
    assign page_fault   = (state == FAULT);
    assign bus_busy_out = xfer;
    assign mem_rd_wr    = (state == WRITE);

    // request drops while its beat is answered, then rises for the next one
    assign mem_req = xfer && !beat_done && !mem_data_valid;

    // hold the grant back from downstream while we want the bus
    assign grant_out = grant_in && !(xfer || (state == BUS_WAIT));

endmodule

//--- verilog/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           rd_req_valid,
    output logic                           rd_req_ready,
    input  vaddr_t                         rd_req_address,
    output logic                           rd_dp_valid,
    input  logic                           rd_dp_ready,
    output line_t                          rd_dp_read_data,
    input  logic                           wr_req_valid,
    output logic                           wr_req_ready,
    input  vaddr_t                         wr_req_address,
    input  line_t                          wr_req_data,
    input  logic                           wr_size,
    output logic                           page_fault,
    input  logic                           cfg_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] cfg_index,
    input  tlb_entry_t                     cfg_entry,
    output paddr_t                         mem_addr,
    output logic                           mem_req,
    output logic                           mem_rd_wr,
    output word_t                          mem_wdata,
    output logic                           bus_busy_out,
    output logic                           grant_out,
    input  logic                           mem_data_valid,
    input  word_t                          mem_rdata,
    input  logic                           grant_in,
    input  logic                           bus_busy_in
);

    tlb_resp_t tlb_resp;
    dp_ctrl_t  ctrl;
    vaddr_t    vaddr;
    line_t     array_line;
    line_t     fill_line;
    line_t     low_line;
    offset_t   offset;
    logic      second_needed;
    logic      beat_done;
    logic      second_line;
    logic      cache_hit;

    dtlb #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) i_dtlb (
        .clk      (clk),
        .reset    (reset),
        .cfg_we   (cfg_we),
        .cfg_index(cfg_index),
        .cfg_entry(cfg_entry),
        .vaddr    (vaddr),
        .resp     (tlb_resp)
    );

    dcache_controller i_controller (
        .clk           (clk),
        .reset         (reset),
        .rd_req_valid  (rd_req_valid),
        .rd_dp_ready   (rd_dp_ready),
        .wr_req_valid  (wr_req_valid),
        .cache_hit     (cache_hit),
        .tlb           (tlb_resp),
        .second_needed (second_needed),
        .beat_done     (beat_done),
        .second_line   (second_line),
        .mem_data_valid(mem_data_valid),
        .grant_in      (grant_in),
        .bus_busy_in   (bus_busy_in),
        .rd_req_ready  (rd_req_ready),
        .rd_dp_valid   (rd_dp_valid),
        .wr_req_ready  (wr_req_ready),
        .page_fault    (page_fault),
        .ctrl          (ctrl),
        .mem_req       (mem_req),
        .mem_rd_wr     (mem_rd_wr),
        .bus_busy_out  (bus_busy_out),
        .grant_out     (grant_out)
    );

    dcache_datapath i_datapath (
        .clk           (clk),
        .reset         (reset),
        .rd_req_address(rd_req_address),
        .wr_req_address(wr_req_address),
        .wr_req_data   (wr_req_data),
        .wr_size       (wr_size),
        .tlb_paddr     (tlb_resp.paddr),
        .ctrl          (ctrl),
        .mem_rdata     (mem_rdata),
        .mem_data_valid(mem_data_valid),
        .array_line    (array_line),
        .vaddr         (vaddr),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .fill_line     (fill_line),
        .low_line      (low_line),
        .offset        (offset),
        .second_needed (second_needed),
        .beat_done     (beat_done),
        .second_line   (second_line)
    );

    // virtual index, physical tag
    dcache_arrays i_arrays (
        .clk      (clk),
        .reset    (reset),
        .index    (vaddr[TAG_LSB-1:OFFSET_W]),
        .tag      (tlb_resp.paddr[31:TAG_LSB]),
        .write    (ctrl.array_write),
        .valid_in (ctrl.valid_val),
        .wdata    (fill_line),
        .rdata    (array_line),
        .cache_hit(cache_hit)
    );

    d_align i_align (
        .low_line (low_line),
        .high_line(fill_line),
        .offset   (offset),
        .result   (rd_dp_read_data)
    );

endmodule

//--- bench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        mem_req,
    input  logic        mem_rd_wr,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    output logic        mem_data_valid,
    output logic [31:0] mem_rdata,
    input  logic        hold_busy,
    input  logic        grant_src,
    output logic        grant_in,
    output logic        bus_busy_in,
    output int          read_beats,
    output int          write_beats
);

    logic [7:0]  mem [16384];
    logic [31:0] dly_lfsr;
    logic        pending;
    logic [2:0]  delay;
    logic [13:0] addr_q;
    logic        wr_q;
    logic [31:0] wdata_q;

    assign grant_in    = grant_src;
    assign bus_busy_in = hold_busy;

    task load_byte(input int addr, input logic [7:0] value);
        mem[addr] = value;
    endtask

    // answer delay of 1 to 4 cycles
    function automatic logic [2:0] next_delay();
        logic [1:0] v;
        v = '0;
        for (int i = 0; i < 2; i++) begin
            dly_lfsr = dly_lfsr[0] ? (dly_lfsr >> 1) ^ 32'h80200003 : dly_lfsr >> 1;
            v = {v[0], dly_lfsr[0]};
        end
        return 3'(v) + 3'd1;
    endfunction

    always @(posedge clk) begin
        mem_data_valid <= 1'b0;
        if (reset) begin
            pending     <= 1'b0;
            read_beats  <= 0;
            write_beats <= 0;
        end else if (!pending && mem_req && !mem_data_valid) begin
            pending <= 1'b1;
            delay   <= next_delay();
            addr_q  <= mem_addr[13:0];
            wr_q    <= mem_rd_wr;
            wdata_q <= mem_wdata;
        end else if (pending) begin
            if (delay == 3'd1) begin
                pending        <= 1'b0;
                mem_data_valid <= 1'b1;
                if (wr_q) begin
                    for (int b = 0; b < 4; b++) begin
                        mem[addr_q + 14'(b)] <= wdata_q[b*8 +: 8];
                    end
                    write_beats <= write_beats + 1;
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        mem_rdata[b*8 +: 8] <= mem[addr_q + 14'(b)];
                    end
                    read_beats <= read_beats + 1;
                end
            end else begin
                delay <= delay - 3'd1;
            end
        end
    end

    initial begin
        dly_lfsr       = 32'ha71f;
        mem_data_valid = 1'b0;
        mem_rdata      = '0;
        pending        = 1'b0;
    end

endmodule

//--- bench/tb_dcache_top.sv
`timescale 1ns/1ps

module tb_dcache_top import dcache_pkg::*; ();

    logic       clk;
    logic       reset;
    logic       rd_req_valid;
    logic       rd_req_ready;
    vaddr_t     rd_req_address;
    logic       rd_dp_valid;
    logic       rd_dp_ready;
    line_t      rd_dp_read_data;
    logic       wr_req_valid;
    logic       wr_req_ready;
    vaddr_t     wr_req_address;
    line_t      wr_req_data;
    logic       wr_size;
    logic       page_fault;
    logic       cfg_we;
    logic [2:0] cfg_index;
    tlb_entry_t cfg_entry;
    paddr_t     mem_addr;
    logic       mem_req;
    logic       mem_rd_wr;
    word_t      mem_wdata;
    logic       bus_busy_out;
    logic       grant_out;
    logic       mem_data_valid;
    word_t      mem_rdata;
    logic       grant_in;
    logic       bus_busy_in;
    logic       hold_busy;
    logic       grant_src;
    int         read_beats;
    int         write_beats;

    logic [31:0] rng;
    logic [7:0]  ref_mem [16384];
    int          ppn_of [4];
    paddr_t      wr_addr_q[$];
    word_t       wr_data_q[$];
    int          errors;
    int          checks;
    int          tests;
    int          failed;
    int          test_start;

    dcache_top #(.TLB_ENTRIES(8)) i_dut (.*);

    tb_mem_model i_mem (.*);

    always #5 clk = ~clk;

    // log write beats mid cycle
    always @(negedge clk) begin
        if (mem_data_valid && mem_rd_wr) begin
            wr_addr_q.push_back(mem_addr);
            wr_data_q.push_back(mem_wdata);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_next(rng);
            v = {v[30:0], rng[0]};
        end
        return v;
    endfunction

    function automatic paddr_t translate(input vaddr_t va);
        return {12'(ppn_of[va[13:12]]), va[11:0]};
    endfunction

    function automatic line_t expected_line(input vaddr_t va);
        line_t  l;
        paddr_t pa;
        for (int b = 0; b < 8; b++) begin
            pa = translate(va + b);
            l[b*8 +: 8] = ref_mem[pa[13:0]];
        end
        return l;
    endfunction

    // keeps a random page offset clear of the page end
    function automatic vaddr_t in_page(input int vpn, input logic [11:0] off);
        if (off > 12'hff0) begin
            off = off & 12'h7ff;
        end
        return {20'(vpn), off};
    endfunction

    task tick();
        @(posedge clk);
        #1;
    endtask

    task abort_run(input string msg);
        $display("%0t ns: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task check_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("%0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    task report_test(input string name);
        tests++;
        if (errors > test_start) begin
            failed++;
            $display("test %s: FAILED", name);
        end else begin
            $display("test %s: ok", name);
        end
        test_start = errors;
    endtask

    task do_read(input vaddr_t va, input logic stall, input int hold);
        line_t exp;
        line_t held;
        logic  seen;
        int    n;
        exp = expected_line(va);
        rd_req_valid   = 1'b1;
        rd_req_address = va;
        n = 0;
        while (!rd_req_ready) begin
            tick();
            if (++n > 50) abort_run("read request never accepted");
        end
        tick();
        rd_req_valid = 1'b0;
        for (int i = 0; i < hold; i++) begin
            check_true(!mem_req && !bus_busy_out, "bus used while another master was busy");
            tick();
        end
        // the cache is waiting for the bus here
        if (hold > 0) begin
            check_value("grant_out", 0, grant_out);
        end
        hold_busy = 1'b0;
        seen = 1'b0;
        n = 0;
        while (1) begin
            if (rd_dp_valid) begin
                check_value("rd_dp_read_data", exp, rd_dp_read_data);
                if (seen) check_value("rd_dp_read_data (held)", held, rd_dp_read_data);
                held = rd_dp_read_data;
                seen = 1'b1;
                if (rd_dp_ready) break;
            end
            tick();
            rd_dp_ready = stall ? (rand_bits(2) != 0) : 1'b1;
            if (++n > 200) abort_run("no read response");
        end
        tick();
        rd_dp_ready = 1'b1;
    endtask

    task do_write(input vaddr_t va, input logic size, input line_t data);
        int     n;
        int     beats;
        int     wb;
        paddr_t pa;
        beats = size ? 2 : 1;
        pa = translate(va);
        wb = write_beats;
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_req_valid   = 1'b1;
        wr_req_address = va;
        wr_req_data    = data;
        wr_size        = size;
        n = 0;
        while (!wr_req_ready) begin
            tick();
            if (++n > 50) abort_run("write request never accepted");
        end
        tick();
        wr_req_valid = 1'b0;
        n = 0;
        while (!wr_req_ready) begin
            tick();
            if (++n > 200) abort_run("write never completed");
        end
        check_value("write beats", beats, write_beats - wb);
        check_value("write log size", beats, wr_addr_q.size());
        for (int i = 0; i < beats && i < wr_addr_q.size(); i++) begin
            check_value("mem_addr", pa + 4 * i, wr_addr_q[i]);
            check_value("mem_wdata", data[i*32 +: 32], wr_data_q[i]);
        end
        for (int b = 0; b < beats * 4; b++) begin
            ref_mem[translate(va + b) & 14'h3fff] = data[b*8 +: 8];
        end
    endtask

    task expect_fault(input vaddr_t va, input logic is_wr);
        int n;
        int beats;
        beats = read_beats + write_beats;
        if (is_wr) begin
            wr_req_valid   = 1'b1;
            wr_req_address = va;
            wr_size        = 1'b0;
        end else begin
            rd_req_valid   = 1'b1;
            rd_req_address = va;
        end
        tick();
        rd_req_valid = 1'b0;
        wr_req_valid = 1'b0;
        n = 0;
        while (!page_fault) begin
            check_true(!rd_dp_valid, "read response on a faulting request");
            tick();
            if (++n > 10) abort_run("page_fault never raised");
        end
        tick();
        check_true(!page_fault, "page_fault longer than one cycle");
        check_true(rd_req_ready, "cache not ready after a fault");
        check_value("bus beats", beats, read_beats + write_beats);
    endtask

    initial begin
        vaddr_t va;
        line_t  data;
        int     rb;
        int     vpn;
        logic   size;
        clk = 0;
        reset = 1;
        rd_req_valid = 0;
        rd_req_address = '0;
        rd_dp_ready = 1;
        wr_req_valid = 0;
        wr_req_address = '0;
        wr_req_data = '0;
        wr_size = 0;
        cfg_we = 0;
        cfg_index = '0;
        cfg_entry = '0;
        hold_busy = 0;
        grant_src = 1;
        rng = 32'ha71f;
        errors = 0;
        checks = 0;
        tests = 0;
        failed = 0;
        test_start = 0;
        ppn_of = '{2, 0, 3, 1};
        for (int a = 0; a < 16384; a++) begin
            ref_mem[a] = rand_bits(8);
            i_mem.load_byte(a, ref_mem[a]);
        end
        tick();
        tick();
        reset = 0;

        // map virtual pages 0 to 3 with page 1 uncacheable and page 2 read-only
        for (int i = 0; i < 4; i++) begin
            cfg_we = 1;
            cfg_index = 3'(i);
            cfg_entry.valid = 1;
            cfg_entry.vpn = vpn_t'(i);
            cfg_entry.ppn = ppn_t'(ppn_of[i]);
            cfg_entry.pcd = (i == 1);
            cfg_entry.writable = (i != 2);
            tick();
        end
        cfg_we = 0;

        va = in_page(3, rand_bits(12) & 12'hff8);
        for (int i = 0; i < 2; i++) begin
            rb = read_beats;
            do_read(va, 0, 0);
            check_value("read beats (cacheable)", i == 0 ? 2 : 0, read_beats - rb);
        end
        va = in_page(1, rand_bits(12) & 12'hff8);
        for (int i = 0; i < 2; i++) begin
            rb = read_beats;
            do_read(va, 0, 0);
            check_value("read beats (pcd)", 2, read_beats - rb);
        end
        report_test("repeated reads hit");

        for (int i = 0; i < 20; i++) begin
            do_read(in_page(rand_bits(2), rand_bits(12) & 12'hff8), 1, 0);
        end
        report_test("aligned reads with stalls");

        for (int i = 0; i < 20; i++) begin
            va = in_page(rand_bits(2), rand_bits(12));
            if (va[2:0] == 3'd0) va[0] = 1'b1;
            do_read(va, 1, 0);
        end
        report_test("line crossing reads");

        // lines are read in first so that the write has to invalidate them
        for (int i = 0; i < 12; i++) begin
            vpn = rand_bits(2);
            if (vpn == 2) vpn = 3;
            va = in_page(vpn, rand_bits(12) & 12'hffc);
            size = rand_bits(1);
            data = {rand_bits(32), rand_bits(32)};
            do_read(va, 0, 0);
            do_write(va, size, data);
            do_read(va, 0, 0);
        end
        report_test("write-through");

        expect_fault(in_page(5, rand_bits(12) & 12'hff8), 0);
        do_read(in_page(0, 12'h040), 0, 0);
        expect_fault(in_page(2, rand_bits(12) & 12'hffc), 1);
        do_read(in_page(2, 12'h080), 0, 0);
        report_test("page faults");

        for (int i = 0; i < 8; i++) begin
            grant_src = rand_bits(1);
            #1;
            check_value("grant_out", grant_src, grant_out);
            tick();
        end
        grant_src = 1;
        hold_busy = 1;
        do_read(in_page(1, 12'h100), 0, 10);
        report_test("bus sharing");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- compile.f
common/dcache_pkg.sv
verilog/dtlb.sv
dcache/dcache_arrays.sv
dcache/d_align.sv
dcache/dcache_datapath.sv
dcache/dcache_controller.sv
verilog/dcache_top.sv
bench/tb_mem_model.sv
bench/tb_dcache_top.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - common/dcache_pkg.sv
  - verilog/dtlb.sv
  - dcache/dcache_arrays.sv
  - dcache/d_align.sv
  - dcache/dcache_datapath.sv
  - dcache/dcache_controller.sv
  - verilog/dcache_top.sv
  - target: test
    files:
      - bench/tb_mem_model.sv
      - bench/tb_dcache_top.sv
